//--- hw/ssm_pkg.sv
// ssm_pkg: shared widths, Q8.8 multiply and stage payload structs for the SSM tile pipeline
`default_nettype none

package ssm_pkg;

    // ==========================================================================
    // format and sizes
    // ==========================================================================
    // one data word, signed Q8.8
    localparam int DATA_W          = 16;
    localparam int FRAC_BITS       = 8;
    // lanes carried by one tile
    localparam int N_TILE          = 4;
    // tiles whose partial sums build one y
    localparam int TILES_PER_GROUP = 4;

    typedef logic signed [DATA_W-1:0] fx_t;
    // lane 0 sits in the low word
    typedef fx_t [N_TILE-1:0] lane_vec_t;

    // full product, arithmetic shift back to Q8.8, keep the low word
    function automatic fx_t fx_mul(input fx_t lhs, input fx_t rhs);
        logic signed [2*DATA_W-1:0] prod;
        prod = lhs * rhs;
        return fx_t'(prod >>> FRAC_BITS);
    endfunction

    // ==========================================================================
    // stage payloads
    // ==========================================================================
    // raw tile from the outside
    typedef struct packed {
        fx_t       dt;
        fx_t       dt_bias;
        fx_t       a;
        fx_t       x;
        fx_t       d;
        lane_vec_t b;
        lane_vec_t c;
        lane_vec_t hprev;
    } tile_in_t;

    // scalar stage -> state stage
    typedef struct packed {
        fx_t       da;
        fx_t       dx;
        fx_t       xd;
        lane_vec_t b;
        lane_vec_t c;
        lane_vec_t hprev;
        logic      grp_first;
        logic      grp_last;
    } state_in_t;

    // state stage -> readout stage
    typedef struct packed {
        lane_vec_t hnext;
        lane_vec_t c;
        fx_t       xd;
        logic      grp_first;
        logic      grp_last;
    } readout_in_t;

    // readout stage -> group accumulator
    typedef struct packed {
        fx_t  psum;
        fx_t  xd;
        logic grp_first;
        logic grp_last;
    } part_sum_t;

endpackage

`default_nettype wire

//--- hw/ssm_scalar_stage.sv
// ssm_scalar_stage: tags group position, adds the step bias and forms dA, dx and xD over two cycles
`default_nettype none
`timescale 1ns/1ps

module ssm_scalar_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  ssm_pkg::tile_in_t    tile_i,
    input  logic                 tile_valid_i,
    output ssm_pkg::state_in_t   st_o,
    output logic                 st_valid_o
);
    import ssm_pkg::*;

    // position of the next tile inside its group
    typedef logic [$clog2(TILES_PER_GROUP)-1:0] cnt_t;

    // first pipeline register, delta already summed
    typedef struct packed {
        fx_t       delta;
        fx_t       a;
        fx_t       x;
        fx_t       d;
        lane_vec_t b;
        lane_vec_t c;
        lane_vec_t hprev;
        logic      grp_first;
        logic      grp_last;
    } s1_t;

    cnt_t tile_cnt;
    logic cnt_first;
    logic cnt_last;
    s1_t  s1;
    logic s1_valid;

    // ==========================================================================
    // group position counter
    // ==========================================================================
    assign cnt_first = (tile_cnt == '0);
    assign cnt_last  = (tile_cnt == cnt_t'(TILES_PER_GROUP - 1));

    // advance on every accepted tile, wrap after the group's last one
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_cnt <= '0;
        end else if (tile_valid_i) begin
            if (cnt_last) begin
                tile_cnt <= '0;
            end else begin
                tile_cnt <= tile_cnt + cnt_t'(1);
            end
        end
    end

    // ==========================================================================
    // cycle 1: delta and flags
    // ==========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= tile_valid_i;
        end
    end

    // payload, only meaningful next to s1_valid
    always_ff @(posedge clk) begin
        // delta wraps like every other sum
        s1.delta     <= tile_i.dt + tile_i.dt_bias;
        s1.a         <= tile_i.a;
        s1.x         <= tile_i.x;
        s1.d         <= tile_i.d;
        s1.b         <= tile_i.b;
        s1.c         <= tile_i.c;
        s1.hprev     <= tile_i.hprev;
        s1.grp_first <= cnt_first;
        s1.grp_last  <= cnt_last;
    end

    // ==========================================================================
    // cycle 2: scalar products
    // ==========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st_valid_o <= 1'b0;
        end else begin
            st_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        // no softplus / exp, the raw products feed the state update
        st_o.da        <= fx_mul(s1.delta, s1.a);
        st_o.dx        <= fx_mul(s1.delta, s1.x);
        // skip term, only the group's first copy is used later
        st_o.xd        <= fx_mul(s1.x, s1.d);
        st_o.b         <= s1.b;
        st_o.c         <= s1.c;
        st_o.hprev     <= s1.hprev;
        st_o.grp_first <= s1.grp_first;
        st_o.grp_last  <= s1.grp_last;
    end

endmodule

`default_nettype wire

//--- hw/ssm_state_stage.sv
// ssm_state_stage: one-cycle per-lane state update hnext = dA*hprev + dx*B
`default_nettype none
`timescale 1ns/1ps

module ssm_state_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  ssm_pkg::state_in_t   st_i,
    input  logic                 st_valid_i,
    output ssm_pkg::readout_in_t rd_o,
    output logic                 rd_valid_o
);
    import ssm_pkg::*;

    // combinational new state, one word per lane
    lane_vec_t hnext;

    // ==========================================================================
    // lane update
    // ==========================================================================
    always_comb begin
        for (int i = 0; i < N_TILE; i++) begin
            // decay of the old state plus the input drive
            // sum wraps at 16 bits
            hnext[i] = fx_mul(st_i.da, st_i.hprev[i]) + fx_mul(st_i.dx, st_i.b[i]);
        end
    end

    // ==========================================================================
    // output register
    // ==========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= st_valid_i;
        end
    end

    // payload travels beside rd_valid_o
    always_ff @(posedge clk) begin
        rd_o.hnext     <= hnext;
        // C and the skip term ride along for the readout
        rd_o.c         <= st_i.c;
        rd_o.xd        <= st_i.xd;
        rd_o.grp_first <= st_i.grp_first;
        rd_o.grp_last  <= st_i.grp_last;
    end

endmodule

`default_nettype wire

//--- hw/ssm_readout_stage.sv
// ssm_readout_stage: weights each lane state by C and reduces the tile to one partial sum
`default_nettype none
`timescale 1ns/1ps

module ssm_readout_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  ssm_pkg::readout_in_t rd_i,
    input  logic                 rd_valid_i,
    output ssm_pkg::part_sum_t   ps_o,
    output logic                 ps_valid_o
);
    import ssm_pkg::*;

    // heap-ordered adder tree
    // leaves at N_TILE-1 .. 2*N_TILE-2, root at 0
    fx_t tree [2*N_TILE-1];

    // ==========================================================================
    // C weighting and lane reduction
    // ==========================================================================
    always_comb begin
        for (int i = 0; i < N_TILE; i++) begin
            tree[N_TILE-1+i] = fx_mul(rd_i.hnext[i], rd_i.c[i]);
        end
        // internal nodes bottom-up, every add wraps
        for (int k = N_TILE - 2; k >= 0; k--) begin
            tree[k] = tree[2*k+1] + tree[2*k+2];
        end
    end

    // ==========================================================================
    // output register
    // ==========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ps_valid_o <= 1'b0;
        end else begin
            ps_valid_o <= rd_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        // one partial per tile
        ps_o.psum      <= tree[0];
        ps_o.xd        <= rd_i.xd;
        ps_o.grp_first <= rd_i.grp_first;
        ps_o.grp_last  <= rd_i.grp_last;
    end

endmodule

`default_nettype wire

//--- hw/ssm_group_accum.sv
// ssm_group_accum: sums tile partials over a group, adds the first tile's xD and pulses y
`default_nettype none
`timescale 1ns/1ps

module ssm_group_accum (
    input  logic               clk,
    input  logic               rstn,
    input  ssm_pkg::part_sum_t ps_i,
    input  logic               ps_valid_i,
    output ssm_pkg::fx_t       y_o,
    output logic               y_valid_o
);
    import ssm_pkg::*;

    // running group sum
    fx_t acc;
    // xD of the group's first tile
    fx_t xd_lat;
    // sum including this tile
    fx_t acc_next;
    // skip term that belongs to this group
    fx_t xd_sel;

    // ==========================================================================
    // next-sum logic
    // ==========================================================================
    // first tile starts over, later tiles add on
    assign acc_next = ps_i.grp_first ? ps_i.psum : acc + ps_i.psum;
    // a group that opens and closes on one tile has no latched xD yet
    assign xd_sel   = ps_i.grp_first ? ps_i.xd : xd_lat;

    // ==========================================================================
    // accumulator and output strobe
    // ==========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc       <= '0;
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= ps_valid_i & ps_i.grp_last;
            if (ps_valid_i) begin
                // clear after the last tile, next group starts fresh
                acc <= ps_i.grp_last ? '0 : acc_next;
            end
        end
    end

    // xD capture, once per group
    always_ff @(posedge clk) begin
        if (ps_valid_i && ps_i.grp_first) begin
            xd_lat <= ps_i.xd;
        end
    end

    // y register, held until the next group closes
    always_ff @(posedge clk) begin
        if (ps_valid_i && ps_i.grp_last) begin
            y_o <= acc_next + xd_sel;
        end
    end

endmodule

`default_nettype wire

//--- hw/ssm_block_top.sv
// ssm_block_top: chains scalar, state, readout and group stages of one SSM step
`default_nettype none
`timescale 1ns/1ps

module ssm_block_top (
    input  logic               clk,
    input  logic               rstn,
    // one strobe per tile, no back-pressure
    input  ssm_pkg::tile_in_t  tile_i,
    input  logic               tile_valid_i,
    // per-tile new state
    output ssm_pkg::lane_vec_t hnext_o,
    output logic               hnext_valid_o,
    // per-group output
    output ssm_pkg::fx_t       y_o,
    output logic               y_valid_o
);
    import ssm_pkg::*;

    // stage-to-stage payloads, valid for one cycle each
    state_in_t   st;
    logic        st_valid;
    readout_in_t rd;
    logic        rd_valid;
    part_sum_t   ps;
    logic        ps_valid;

    // ==========================================================================
    // delta, scalar products, group tagging (2 cycles)
    // ==========================================================================
    ssm_scalar_stage u_scalar (
        .clk          (clk),
        .rstn         (rstn),
        .tile_i       (tile_i),
        .tile_valid_i (tile_valid_i),
        .st_o         (st),
        .st_valid_o   (st_valid)
    );

    // ==========================================================================
    // per-lane state update (1 cycle)
    // ==========================================================================
    ssm_state_stage u_state (
        .clk        (clk),
        .rstn       (rstn),
        .st_i       (st),
        .st_valid_i (st_valid),
        .rd_o       (rd),
        .rd_valid_o (rd_valid)
    );

    // new state leaves straight from the state register
    assign hnext_o       = rd.hnext;
    assign hnext_valid_o = rd_valid;

    // ==========================================================================
    // C readout and lane reduction (1 cycle)
    // ==========================================================================
    ssm_readout_stage u_readout (
        .clk        (clk),
        .rstn       (rstn),
        .rd_i       (rd),
        .rd_valid_i (rd_valid),
        .ps_o       (ps),
        .ps_valid_o (ps_valid)
    );

    // ==========================================================================
    // group sum plus skip term (1 cycle)
    // ==========================================================================
    ssm_group_accum u_accum (
        .clk        (clk),
        .rstn       (rstn),
        .ps_i       (ps),
        .ps_valid_i (ps_valid),
        .y_o        (y_o),
        .y_valid_o  (y_valid_o)
    );

endmodule

`default_nettype wire

//--- tests/ssm_tb_model.svh
// ssm_tb_model: Q8.8 reference arithmetic, per-tile and per-group expectations, result queues
`ifndef SSM_TB_MODEL_SVH
`define SSM_TB_MODEL_SVH

// output latency in rising edges after the edge that samples a tile
localparam int HNEXT_LAT = 3;
localparam int Y_LAT     = 5;

// ============================================================================
// expected results, oldest first
// ============================================================================
lane_vec_t exp_hnext_q[$];
int        exp_hnext_edge_q[$];
fx_t       exp_y_q[$];
int        exp_y_edge_q[$];

// model view of the current group
int  grp_pos = 0;
fx_t grp_sum = '0;
fx_t grp_xd  = '0;

// full signed product, floor shift back to Q8.8, low word kept
function automatic fx_t qmul(input fx_t lhs, input fx_t rhs);
    int full;
    full = int'(lhs) * int'(rhs);
    return fx_t'(full >>> FRAC_BITS);
endfunction

// modulo 2^16 add
function automatic fx_t wrap_add(input fx_t lhs, input fx_t rhs);
    int full;
    full = int'(lhs) + int'(rhs);
    return fx_t'(full);
endfunction

// hnext = (delta*A)*hprev + (delta*x)*B for every lane
function automatic lane_vec_t next_state(input tile_in_t t);
    lane_vec_t h;
    fx_t       delta;
    fx_t       da;
    fx_t       dx;
    delta = wrap_add(t.dt, t.dt_bias);
    da    = qmul(delta, t.a);
    dx    = qmul(delta, t.x);
    for (int i = 0; i < N_TILE; i++) begin
        h[i] = wrap_add(qmul(da, t.hprev[i]), qmul(dx, t.b[i]));
    end
    return h;
endfunction

// C-weighted lanes, summed in lane order (wrap makes the order irrelevant)
function automatic fx_t weighted_sum(input lane_vec_t h, input lane_vec_t c);
    fx_t s;
    s = '0;
    for (int i = 0; i < N_TILE; i++) begin
        s = wrap_add(s, qmul(h[i], c[i]));
    end
    return s;
endfunction

// ============================================================================
// bookkeeping per sent tile
// ============================================================================
task automatic expect_tile(input tile_in_t t, input int sample_edge);
    lane_vec_t h;
    fx_t       part;
    h    = next_state(t);
    part = weighted_sum(h, t.c);
    exp_hnext_q.push_back(h);
    exp_hnext_edge_q.push_back(sample_edge + HNEXT_LAT);
    // the skip term comes from the group's first tile only
    if (grp_pos == 0) begin
        grp_sum = part;
        grp_xd  = qmul(t.x, t.d);
    end else begin
        grp_sum = wrap_add(grp_sum, part);
    end
    grp_pos++;
    if (grp_pos == TILES_PER_GROUP) begin
        exp_y_q.push_back(wrap_add(grp_sum, grp_xd));
        exp_y_edge_q.push_back(sample_edge + Y_LAT);
        grp_pos = 0;
    end
endtask

// a reset throws away any partial group
task automatic clear_group();
    grp_pos = 0;
    grp_sum = '0;
endtask

`endif

//--- tests/ssm_block_tb.sv
// ssm_block_tb: random tile stream through the SSM pipeline, checked against a Q8.8 model
`default_nettype none
`timescale 1ns/1ps

module ssm_block_tb;
    import ssm_pkg::*;

    // at most 4 cycles per tile with the longest gap, plus room for resets and drain
    localparam int TIMEOUT_CYCLES = 200 * 4 + 100;

    logic      clk;
    logic      rstn;
    tile_in_t  tile_i;
    logic      tile_valid_i;
    lane_vec_t hnext_o;
    logic      hnext_valid_o;
    fx_t       y_o;
    logic      y_valid_o;

    integer seed;
    // rising edges so far
    int cyc = 0;

    `include "ssm_tb_model.svh"

    ssm_block_top u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .tile_i        (tile_i),
        .tile_valid_i  (tile_valid_i),
        .hnext_o       (hnext_o),
        .hnext_valid_o (hnext_valid_o),
        .y_o           (y_o),
        .y_valid_o     (y_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ========================================================================
    // failure path and compare tasks
    // ========================================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hnext(input lane_vec_t exp, input lane_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: hnext_o expected %h actual %h", exp, act));
        end
    endtask

    task automatic check_y(input fx_t exp, input fx_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: y_o expected %h actual %h", exp, act));
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    // signed value in (-span, span), raw Q8.8 units
    function automatic fx_t small_value(input int span);
        int r;
        r = $random(seed) % span;
        return fx_t'(r);
    endfunction

    // ranges keep hnext unwrapped while the group sum still wraps now and then
    function automatic tile_in_t random_tile();
        tile_in_t t;
        t.dt      = small_value(128);
        t.dt_bias = small_value(128);
        t.a       = small_value(256);
        t.x       = small_value(1024);
        t.d       = small_value(256);
        for (int i = 0; i < N_TILE; i++) begin
            t.b[i]     = small_value(512);
            t.c[i]     = small_value(512);
            t.hprev[i] = small_value(2048);
        end
        return t;
    endfunction

    // called right after a falling edge, the next rising edge takes the tile
    task automatic send_tile(input int max_gap);
        int       gap;
        tile_in_t t;
        t   = random_tile();
        gap = int'({$random(seed)} % (max_gap + 1));
        tile_i       = t;
        tile_valid_i = 1'b1;
        expect_tile(t, cyc + 1);
        @(negedge clk);
        tile_valid_i = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // reset held for two cycles, then a few quiet cycles
    task automatic apply_reset();
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        clear_group();
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_drain();
        while (exp_hnext_q.size() != 0 || exp_y_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ========================================================================
    // output monitor
    // ========================================================================
    // a value seen at a falling edge is the one the next rising edge takes
    task automatic watch_hnext();
        if (hnext_valid_o) begin
            if (exp_hnext_q.size() == 0) begin
                abort_run("hnext_valid_o pulsed with no tile outstanding");
            end else if (exp_hnext_edge_q[0] != cyc + 1) begin
                abort_run($sformatf("hnext_valid_o came at edge %0d instead of edge %0d",
                                    cyc + 1, exp_hnext_edge_q[0]));
            end else begin
                check_hnext(exp_hnext_q.pop_front(), hnext_o);
                void'(exp_hnext_edge_q.pop_front());
            end
        end else if (exp_hnext_q.size() != 0 && exp_hnext_edge_q[0] <= cyc + 1) begin
            abort_run("hnext_valid_o did not pulse for a sampled tile");
        end
    endtask

    task automatic watch_y();
        if (y_valid_o) begin
            if (exp_y_q.size() == 0) begin
                abort_run("y_valid_o pulsed with no completed group outstanding");
            end else if (exp_y_edge_q[0] != cyc + 1) begin
                abort_run($sformatf("y_valid_o came at edge %0d instead of edge %0d",
                                    cyc + 1, exp_y_edge_q[0]));
            end else begin
                check_y(exp_y_q.pop_front(), y_o);
                void'(exp_y_edge_q.pop_front());
            end
        end else if (exp_y_q.size() != 0 && exp_y_edge_q[0] <= cyc + 1) begin
            abort_run("y_valid_o did not pulse for a completed group");
        end
    endtask

    always @(negedge clk) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the pipeline did not deliver every output in time");
        end else if (!rstn) begin
            if (hnext_valid_o || y_valid_o) begin
                abort_run("an output valid was high while reset was asserted");
            end
        end else begin
            watch_hnext();
            watch_y();
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        seed         = 42;
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        tile_i       = '0;
        apply_reset();
        // back to back, five tiles in flight
        repeat (64) send_tile(0);
        // half a group, then a reset drops it
        repeat (2) send_tile(0);
        wait_drain();
        apply_reset();
        // random gaps, the first four tiles form a fresh group
        repeat (134) send_tile(3);
        wait_drain();
        // room for any stray pulse to show up
        repeat (8) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tests
hw/ssm_pkg.sv
hw/ssm_scalar_stage.sv
hw/ssm_state_stage.sv
hw/ssm_readout_stage.sv
hw/ssm_group_accum.sv
hw/ssm_block_top.sv
tests/ssm_block_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the SSM pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

# the package carries no timescale of its own
verilator --binary --timescale 1ns/1ps -f list.f --top-module ssm_block_tb -o ssm_block_sim

# a $fatal in the run gives a non-zero exit status
./obj_dir/ssm_block_sim
